/* mpmc_pkg.sv */
package mpmc_pkg;

	// ==================================================
	// Sizes
	// ==================================================

	// Byte address width on the memory side
	localparam int addr_w = 32;

	// Byte offset bits within one cache line, giving a 32 byte line
	localparam int line_off_w = 5;

	// Line address width, the address bits above the line offset
	localparam int line_w = addr_w - line_off_w;

	// One returned data beat fills exactly one line
	localparam int beat_w = 256;

	// Burst length and beat count width
	localparam int burst_w = 6;

	// Line index bits of the cache and the number of lines they give
	localparam int cache_idx_w = 6;
	localparam int cache_lines = 1 << cache_idx_w;

	// The load address comes out of reset pointing at the top line
	localparam logic [addr_w-1:0] addr_reset_val = {{line_w{1'b1}}, {line_off_w{1'b0}}};

	// ==================================================
	// Types
	// ==================================================

	// Fill sequence, shared by the FSM and the stages that follow it
	typedef enum logic [2:0] {
		IDLE,
		PRESET1,
		PRESET2,
		READ_DATA0,
		READ_DATA1,
		DONE
	} mpmc_state_t;

	// Client request, len is the number of beats minus one
	typedef struct packed {
		logic [addr_w-1:0]  addr;
		logic [burst_w-1:0] len;
	} fill_req_t;

	// One beat as returned by the memory
	typedef struct packed {
		logic              valid;
		logic [beat_w-1:0] data;
	} mem_beat_t;

	// Write into the line cache
	typedef struct packed {
		logic              en;
		logic [line_w-1:0] line;
		logic [beat_w-1:0] data;
	} cache_wr_t;

endpackage

/* mpmc_fill_fsm.sv */
`timescale 1ns/10ps

module mpmc_fill_fsm
	import mpmc_pkg::*;
(
	input  logic               clk,
	input  logic               rst,
	input  logic               req_strobe,
	input  fill_req_t          req,
	input  logic [burst_w-1:0] burst_cnt,
	input  logic               beat_valid,
	output mpmc_state_t        state,
	output logic [burst_w-1:0] burst_len,
	output logic [addr_w-1:0]  addr_base,
	output logic               busy,
	output logic               mem_rd_cmd,
	output logic               fill_done,
	output logic [addr_w-1:0]  mem_rd_addr,
	output logic [burst_w-1:0] mem_rd_len
);

	mpmc_state_t state_nxt;
	logic        req_accept;
	logic        last_beat;

	// A strobe only counts while nothing else is in flight
	assign req_accept = (state == IDLE) && req_strobe;

	// The final beat is the one that arrives once the count has reached the length
	assign last_beat = beat_valid && (burst_cnt == burst_len);

	// ==================================================
	// State sequencing
	// ==================================================

	always_comb begin
		state_nxt = state;
		case (state)
		IDLE: begin
			if (req_accept)
				state_nxt = PRESET1;
		end
		// Two preset cycles give the counter and the load address time to settle
		PRESET1:
			state_nxt = PRESET2;
		PRESET2:
			state_nxt = READ_DATA0;
		// The burst read command goes out here
		READ_DATA0:
			state_nxt = READ_DATA1;
		READ_DATA1: begin
			// Gaps between beats just keep us here
			if (last_beat)
				state_nxt = DONE;
		end
		DONE:
			state_nxt = IDLE;
		default:
			state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			state <= IDLE;
		else
			state <= state_nxt;
	end

	// ==================================================
	// Request capture
	// ==================================================

	// Length and base are held for the whole fill and broadcast to the later stages
	always_ff @(posedge clk) begin
		if (req_accept) begin
			burst_len <= req.len;
			addr_base <= req.addr;
		end
	end

	// ==================================================
	// Outputs
	// ==================================================

	// Busy covers everything from PRESET1 through DONE
	assign busy = (state != IDLE);

	// Single cycle read command, since READ_DATA0 lasts one cycle
	assign mem_rd_cmd = (state == READ_DATA0);

	// Memory is addressed in whole lines
	assign mem_rd_addr = {addr_base[addr_w-1:line_off_w], {line_off_w{1'b0}}};
	assign mem_rd_len = burst_len;

	// Completion pulse, one cycle after the final beat
	assign fill_done = (state == DONE);

endmodule

/* mpmc_burst_counter.sv */
`timescale 1ns/10ps

module mpmc_burst_counter
	import mpmc_pkg::*;
(
	input  logic               clk,
	input  logic               rst,
	input  mpmc_state_t        state,
	input  logic               beat_valid,
	input  logic [burst_w-1:0] burst_len,
	output logic [burst_w-1:0] burst_cnt
);

	logic below_len;

	// Counting stops once the length is reached
	assign below_len = (burst_cnt < burst_len);

	// ==================================================
	// Beat counter
	// ==================================================

	// Cleared ahead of the command so the first beat sees a count of zero.
	// After the last beat the count sits at the length, which keeps any
	// surplus beats from wrapping it back into range
	always_ff @(posedge clk) begin
		if (rst) begin
			burst_cnt <= '0;
		end
		else if (state == PRESET2) begin
			burst_cnt <= '0;
		end
		else if (beat_valid && below_len) begin
			burst_cnt <= burst_cnt + burst_w'(1);
		end
	end

endmodule

/* mpmc_waddr_gen.sv */
`timescale 1ns/10ps

module mpmc_waddr_gen
	import mpmc_pkg::*;
(
	input  logic               clk,
	input  logic               rst,
	input  mpmc_state_t        state,
	input  mem_beat_t          beat,
	input  logic [burst_w-1:0] burst_len,
	input  logic [burst_w-1:0] burst_cnt,
	input  logic [addr_w-1:0]  addr_base,
	output cache_wr_t          cache_wr
);

	// Cache load address, offset bits stay zero once loaded
	logic [addr_w-1:0] addr;

	// Set while beats of the current burst are still expected
	logic on;

	logic last_beat;
	logic advance;

	// The beat carrying the final count ends the burst
	assign last_beat = beat.valid && (burst_cnt == burst_len);

	// Step to the next line after every written beat but the last
	assign advance = beat.valid && on && (burst_cnt != burst_len);

	// ==================================================
	// Load address and write window
	// ==================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			addr <= addr_reset_val;
			on <= 1'b0;
		end
		else begin
			// Open the window as the command goes out
			if (state == READ_DATA0)
				on <= 1'b1;
			// Anything after the final beat is surplus and must not land in the cache
			if (last_beat)
				on <= 1'b0;
			if (state == PRESET2)
				addr <= {addr_base[addr_w-1:line_off_w], {line_off_w{1'b0}}};
			else if (advance)
				addr[addr_w-1:line_off_w] <= addr[addr_w-1:line_off_w] + line_w'(1);
		end
	end

	// Beats are written the cycle they arrive
	always_comb begin
		cache_wr.en = beat.valid && on;
		cache_wr.line = addr[addr_w-1:line_off_w];
		cache_wr.data = beat.data;
	end

endmodule

/* mpmc_line_cache.sv */
`timescale 1ns/10ps

module mpmc_line_cache
	import mpmc_pkg::*;
(
	input  logic                   clk,
	input  cache_wr_t              cache_wr,
	input  logic [cache_idx_w-1:0] lookup_idx,
	output logic [beat_w-1:0]      lookup_data
);

	// ==================================================
	// Line storage
	// ==================================================

	// One full beat per line
	logic [beat_w-1:0] lines [cache_lines];

	// Lines are direct mapped on the low bits of the line address
	logic [cache_idx_w-1:0] wr_idx;

	assign wr_idx = cache_wr.line[cache_idx_w-1:0];

	// Fill port
	always_ff @(posedge clk) begin
		if (cache_wr.en)
			lines[wr_idx] <= cache_wr.data;
	end

	// ==================================================
	// Lookup port
	// ==================================================

	// Registered read. A line being filled in the same cycle still reads
	// back its previous content, the new data shows on the next lookup
	always_ff @(posedge clk) begin
		lookup_data <= lines[lookup_idx];
	end

endmodule

/* mpmc_fill_top.sv */
`timescale 1ns/10ps

module mpmc_fill_top
	import mpmc_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   req_strobe,
	input  fill_req_t              req,
	input  mem_beat_t              mem_beat,
	input  logic [cache_idx_w-1:0] lookup_idx,
	output logic                   busy,
	output logic                   mem_rd_cmd,
	output logic [addr_w-1:0]      mem_rd_addr,
	output logic [burst_w-1:0]     mem_rd_len,
	output logic                   fill_done,
	output logic [beat_w-1:0]      lookup_data
);

	// Broadcast from the FSM to the later stages
	mpmc_state_t        state;
	logic [burst_w-1:0] burst_len;
	logic [addr_w-1:0]  addr_base;

	// Running beat count of the current burst
	logic [burst_w-1:0] burst_cnt;

	// Write from the address generator into the cache
	cache_wr_t cache_wr;

	// ==================================================
	// Fill pipeline
	// ==================================================

	mpmc_fill_fsm fsm_i (
		.clk(clk),
		.rst(rst),
		.req_strobe(req_strobe),
		.req(req),
		.burst_cnt(burst_cnt),
		.beat_valid(mem_beat.valid),
		.state(state),
		.burst_len(burst_len),
		.addr_base(addr_base),
		.busy(busy),
		.mem_rd_cmd(mem_rd_cmd),
		.fill_done(fill_done),
		.mem_rd_addr(mem_rd_addr),
		.mem_rd_len(mem_rd_len)
	);

	mpmc_burst_counter cnt_i (
		.clk(clk),
		.rst(rst),
		.state(state),
		.beat_valid(mem_beat.valid),
		.burst_len(burst_len),
		.burst_cnt(burst_cnt)
	);

	mpmc_waddr_gen waddr_i (
		.clk(clk),
		.rst(rst),
		.state(state),
		.beat(mem_beat),
		.burst_len(burst_len),
		.burst_cnt(burst_cnt),
		.addr_base(addr_base),
		.cache_wr(cache_wr)
	);

	mpmc_line_cache cache_i (
		.clk(clk),
		.cache_wr(cache_wr),
		.lookup_idx(lookup_idx),
		.lookup_data(lookup_data)
	);

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen (
	output logic clk,
	output logic rst
);

	// 8 ns clock period
	localparam int half_period = 4;

	// Reset spans this many rising edges
	localparam int reset_cycles = 4;

	initial begin
		clk = 1'b0;
		forever #half_period clk = ~clk;
	end

	// Reset is released on a falling edge, like all other stimulus
	initial begin
		rst = 1'b1;
		repeat (reset_cycles) @(negedge clk);
		rst = 1'b0;
	end

endmodule

/* tb_mpmc_fill.sv */
`timescale 1ns/10ps

module tb_mpmc_fill
	import mpmc_pkg::*;
;

	// Three directed fills followed by random ones
	localparam int num_requests = 12;
	localparam int max_cycles = 40 * num_requests + 100;

	logic                   clk;
	logic                   rst;
	logic                   req_strobe;
	fill_req_t              req;
	mem_beat_t              mem_beat;
	logic [cache_idx_w-1:0] lookup_idx;
	logic                   busy;
	logic                   mem_rd_cmd;
	logic [addr_w-1:0]      mem_rd_addr;
	logic [burst_w-1:0]     mem_rd_len;
	logic                   fill_done;
	logic [beat_w-1:0]      lookup_data;

	// Reference image of the cache as the memory model builds it from the request
	logic [beat_w-1:0] ref_mem [cache_lines];
	logic              ref_valid [cache_lines];

	// Expected command of the request in flight
	logic [addr_w-1:0]  exp_addr;
	logic [burst_w-1:0] exp_len;

	// Set on the last beat of a burst, never on surplus beats
	logic final_beat;
	logic mem_idle;
	logic strobe_seen;

	// Lookup check delayed one cycle to line up with the registered read
	logic              lookup_chk;
	logic              chk_q;
	logic [beat_w-1:0] exp_q;

	logic [31:0] req_rng;
	logic [31:0] mem_rng;
	int          errors = 0;
	int          lookups = 0;
	int          requests = 0;

	tb_clock_gen clk_gen_i (
		.clk(clk),
		.rst(rst)
	);

	mpmc_fill_top dut_i (
		.clk(clk),
		.rst(rst),
		.req_strobe(req_strobe),
		.req(req),
		.mem_beat(mem_beat),
		.lookup_idx(lookup_idx),
		.busy(busy),
		.mem_rd_cmd(mem_rd_cmd),
		.mem_rd_addr(mem_rd_addr),
		.mem_rd_len(mem_rd_len),
		.fill_done(fill_done),
		.lookup_data(lookup_data)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// ==================================================
	// Checks
	// ==================================================

	always @(posedge clk) begin
		chk_q <= lookup_chk;
		exp_q <= ref_mem[lookup_idx];
	end

	// Nothing moves before the first request
	a_quiet: assert property (@(posedge clk) disable iff (rst)
		!strobe_seen |-> (!busy && !mem_rd_cmd && !fill_done))
	else begin
		errors++;
		$display("Controller became active at %0t before any request", $time);
	end

	// An idle controller takes the strobe and issues the command three cycles later
	a_cmd_timing: assert property (@(posedge clk) disable iff (rst)
		(req_strobe && !busy) |-> ##3 mem_rd_cmd)
	else begin
		errors++;
		$display("No read command 3 cycles after accepted request at %0t", $time);
	end

	// Every command traces back to an accepted strobe so a strobe while busy is dropped
	a_cmd_source: assert property (@(posedge clk) disable iff (rst)
		mem_rd_cmd |-> $past(req_strobe && !busy, 3))
	else begin
		errors++;
		$display("Read command at %0t without an accepted request", $time);
	end

	a_cmd_pulse: assert property (@(posedge clk) disable iff (rst)
		mem_rd_cmd |=> !mem_rd_cmd)
	else begin
		errors++;
		$display("Read command held longer than one cycle at %0t", $time);
	end

	a_cmd_fields: assert property (@(posedge clk) disable iff (rst)
		mem_rd_cmd |-> (mem_rd_addr == exp_addr && mem_rd_len == exp_len))
	else begin
		errors++;
		$display("MISMATCH at %0t: command addr %h len %0d, expected addr %h len %0d",
			$time, $sampled(mem_rd_addr), $sampled(mem_rd_len), exp_addr, exp_len);
	end

	a_done_timing: assert property (@(posedge clk) disable iff (rst)
		final_beat |=> fill_done)
	else begin
		errors++;
		$display("Fill did not complete one cycle after the last beat at %0t", $time);
	end

	a_done_source: assert property (@(posedge clk) disable iff (rst)
		fill_done |-> $past(final_beat))
	else begin
		errors++;
		$display("Fill completed at %0t without a preceding last beat", $time);
	end

	// Busy drops together with the end of the done pulse
	a_busy_end: assert property (@(posedge clk) disable iff (rst)
		fill_done |-> busy ##1 (!busy && !fill_done))
	else begin
		errors++;
		$display("Busy did not fall together with the end of the done pulse at %0t", $time);
	end

	a_lookup: assert property (@(posedge clk) disable iff (rst)
		chk_q |-> (lookup_data == exp_q))
	else begin
		errors++;
		$display("MISMATCH at %0t: lookup returned %h", $time, $sampled(lookup_data));
		$display("MISMATCH at %0t: expected %h", $time, $sampled(exp_q));
	end

	// ==================================================
	// Memory model
	// ==================================================

	initial begin : memory_model
		logic [beat_w-1:0]      data;
		logic [cache_idx_w-1:0] idx;
		int                     n;
		int                     extra;
		mem_beat = '0;
		final_beat = 1'b0;
		mem_idle = 1'b1;
		mem_rng = 32'hd63e;
		for (int i = 0; i < cache_lines; i++)
			ref_valid[i] = 1'b0;
		forever begin
			@(negedge clk);
			if (mem_rd_cmd === 1'b1) begin
				mem_idle = 1'b0;
				n = mem_rd_len;
				// Answer after 1 to 4 cycles and never inside the command cycle
				mem_rng = xorshift32(mem_rng);
				repeat (1 + mem_rng[1:0]) @(negedge clk);
				for (int k = 0; k <= n; k++) begin
					for (int w = 0; w < beat_w / 32; w++) begin
						mem_rng = xorshift32(mem_rng);
						data[32*w +: 32] = mem_rng;
					end
					// Beat k belongs to the k-th line after the request's base line
					idx = exp_addr[line_off_w +: cache_idx_w] + cache_idx_w'(k);
					ref_mem[idx] = data;
					ref_valid[idx] = 1'b1;
					mem_beat.valid = 1'b1;
					mem_beat.data = data;
					final_beat = (k == exp_len);
					@(negedge clk);
					mem_beat.valid = 1'b0;
					final_beat = 1'b0;
					// One idle cycle in four
					mem_rng = xorshift32(mem_rng);
					if (mem_rng[1:0] == 2'd0)
						@(negedge clk);
				end
				// Surplus beats that the controller has to drop
				mem_rng = xorshift32(mem_rng);
				extra = mem_rng[1:0] % 3;
				for (int e = 0; e < extra; e++) begin
					mem_rng = xorshift32(mem_rng);
					mem_beat.valid = 1'b1;
					mem_beat.data = {beat_w / 32{mem_rng}};
					@(negedge clk);
					mem_beat.valid = 1'b0;
				end
				mem_idle = 1'b1;
			end
		end
	end

	// ==================================================
	// Stimulus
	// ==================================================

	// One fill, a stray strobe while busy, then a lookup of every filled line
	// and of the line just past the run
	task automatic run_fill(input logic [addr_w-1:0] addr, input logic [burst_w-1:0] len);
		logic [cache_idx_w-1:0] idx;
		@(negedge clk);
		exp_addr = {addr[addr_w-1:line_off_w], {line_off_w{1'b0}}};
		exp_len = len;
		req.addr = addr;
		req.len = len;
		req_strobe = 1'b1;
		strobe_seen = 1'b1;
		@(negedge clk);
		req.addr = ~addr;
		req.len = ~len;
		@(negedge clk);
		req_strobe = 1'b0;
		while (fill_done !== 1'b1)
			@(negedge clk);
		for (int k = 0; k <= len + 1; k++) begin
			idx = exp_addr[line_off_w +: cache_idx_w] + cache_idx_w'(k);
			lookup_idx = idx;
			lookup_chk = ref_valid[idx];
			if (ref_valid[idx])
				lookups++;
			@(negedge clk);
		end
		lookup_chk = 1'b0;
		while (!mem_idle)
			@(negedge clk);
		requests++;
	endtask

	initial begin : stimulus
		req_strobe = 1'b0;
		req = '0;
		lookup_idx = '0;
		lookup_chk = 1'b0;
		strobe_seen = 1'b0;
		exp_addr = '0;
		exp_len = '0;
		req_rng = 32'hd63e;
		@(negedge clk);
		while (rst)
			@(negedge clk);
		// Idle period right after reset
		repeat (3) @(negedge clk);
		// Full fill from an unaligned base at the top line wraps the index
		run_fill(32'h0000_07e4, 6'd63);
		run_fill(32'h0001_2345, 6'd0);
		run_fill(32'h0000_4000, 6'd3);
		for (int i = 3; i < num_requests; i++) begin
			req_rng = xorshift32(req_rng);
			run_fill(req_rng, {3'b000, req_rng[14:12]});
		end
		repeat (2) @(negedge clk);
		$display("Closing counts: %0d requests, %0d lookups, %0d errors",
			requests, lookups, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	// Cycle limit for the whole run
	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < max_cycles) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", max_cycles);
		$display("Closing counts: %0d requests, %0d lookups, %0d errors",
			requests, lookups, errors);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* src.f */
mpmc_pkg.sv
mpmc_fill_fsm.sv
mpmc_burst_counter.sv
mpmc_waddr_gen.sv
mpmc_line_cache.sv
mpmc_fill_top.sv
tb_clock_gen.sv
tb_mpmc_fill.sv
